/* hw/rename_pkg.sv */
package rename_pkg;

  //////////////////////////////
  // queue geometry
  //////////////////////////////

  localparam int ISQ_DEPTH   = 16;
  // two segments, each with its own header map
  localparam int SEG_LINES   = ISQ_DEPTH / 2;
  localparam int NUM_LREGS   = 16;
  // slots left in a segment when full is raised
  localparam int FULL_MARGIN = 2;

  localparam int LREG_W      = $clog2(NUM_LREGS);
  localparam int PTAG_W      = 6;
  // valid flag above the tag
  localparam int ENTRY_W     = PTAG_W + 1;
  localparam int MAP_W       = NUM_LREGS * ENTRY_W;
  localparam int ISQ_LINE_W  = 24;
  localparam int TPU_INST_W  = 25;
  localparam int QPTR_W      = $clog2(ISQ_DEPTH);

  typedef logic [LREG_W-1:0]     lreg_t;
  typedef logic [PTAG_W-1:0]     ptag_t;
  typedef logic [ENTRY_W-1:0]    map_entry_t;
  // logical register 0 in the lowest entry
  typedef logic [MAP_W-1:0]      rename_map_t;
  typedef logic [ISQ_LINE_W-1:0] isq_line_t;
  typedef logic [TPU_INST_W-1:0] tpu_inst_t;
  typedef logic [QPTR_W-1:0]     qptr_t;

  //////////////////////////////
  // queue line fields
  //////////////////////////////

  localparam int BIT_WAT       = 23;
  localparam int BIT_INST_VLD  = 22;
  localparam int BIT_LSRC1_VLD = 21;
  localparam int POS_LSRC1     = 17;
  localparam int BIT_LSRC2_VLD = 16;
  localparam int POS_LSRC2     = 12;
  localparam int BIT_LDST_VLD  = 11;
  localparam int POS_LDST      = 7;
  localparam int POS_PDEST     = 1;
  localparam int BIT_CTRL      = 0;

  // renamed line fields, bit 0 is a zero pad
  localparam int BIT_OUT_WAT      = 24;
  localparam int BIT_OUT_INST_VLD = 23;
  localparam int POS_PSRC1        = 16;
  localparam int POS_PSRC2        = 9;
  localparam int POS_OUT_PDEST    = 3;
  localparam int BIT_OUT_LDST_VLD = 2;
  localparam int BIT_OUT_CTRL     = 1;

  // logical n -> physical n, all entries valid
  function automatic rename_map_t identity_map();
    rename_map_t m;
    for (int n = 0; n < NUM_LREGS; n++)
    begin
      m[n*ENTRY_W +: ENTRY_W] = {1'b1, ptag_t'(n)};
    end
    return m;
  endfunction

  localparam rename_map_t RESET_MAP = identity_map();

endpackage

/* hw/rename_lines_if.sv */
`timescale 1ns/1ps

interface rename_lines_if
  import rename_pkg::*;
();

  // renamed line per queue slot, raw queue order
  tpu_inst_t               line_out [ISQ_DEPTH];
  // physical reg released by each line's destination
  map_entry_t              fre_preg [ISQ_DEPTH];
  logic [ISQ_DEPTH-1:0]    inst_rdy;
  // invalid or no longer waiting
  logic [ISQ_DEPTH-1:0]    inst_done;

  // map after the last line of each half
  rename_map_t             low_tail_map;
  rename_map_t             high_tail_map;

  modport lines (
    output line_out, fre_preg, inst_rdy, inst_done, low_tail_map, high_tail_map
  );

  modport rotator (
    input line_out, fre_preg, inst_rdy
  );

  modport header (
    input inst_done, low_tail_map, high_tail_map
  );

endinterface

/* hw/tpu_line.sv */
`timescale 1ns/1ps

module tpu_line
  import rename_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  isq_line_t   isq_lin_i,
  input  rename_map_t prv_map_i,
  input  logic        dst_reg_rdy_i,
  input  logic        dst_rdy_reg_en_i,
  output rename_map_t cur_map_o,
  output tpu_inst_t   tpu_out_o,
  output map_entry_t  fre_preg_o,
  output logic        inst_rdy_o,
  output logic        inst_done_o
);

  logic       inst_wat;
  logic       inst_vld;
  logic       lsrc1_vld;
  logic       lsrc2_vld;
  logic       ldst_vld;
  lreg_t      lsrc1;
  lreg_t      lsrc2;
  lreg_t      ldst;
  ptag_t      pdest;
  map_entry_t psrc1;
  map_entry_t psrc2;
  // this line overwrites a map entry
  logic       rename_dst;
  logic       dst_rdy_q;

  //////////////////////////////
  // field decode
  //////////////////////////////

  assign inst_wat  = isq_lin_i[BIT_WAT];
  assign inst_vld  = isq_lin_i[BIT_INST_VLD];
  assign lsrc1_vld = isq_lin_i[BIT_LSRC1_VLD];
  assign lsrc1     = isq_lin_i[POS_LSRC1 +: LREG_W];
  assign lsrc2_vld = isq_lin_i[BIT_LSRC2_VLD];
  assign lsrc2     = isq_lin_i[POS_LSRC2 +: LREG_W];
  assign ldst_vld  = isq_lin_i[BIT_LDST_VLD];
  assign ldst      = isq_lin_i[POS_LDST +: LREG_W];
  assign pdest     = isq_lin_i[POS_PDEST +: PTAG_W];

  assign rename_dst = inst_vld & ldst_vld;

  // source lookup in the map left by the line above
  assign psrc1 = lsrc1_vld ? prv_map_i[ENTRY_W*lsrc1 +: ENTRY_W] : '0;
  assign psrc2 = lsrc2_vld ? prv_map_i[ENTRY_W*lsrc2 +: ENTRY_W] : '0;

  // old mapping of ldst is what gets freed
  assign fre_preg_o = rename_dst ? prv_map_i[ENTRY_W*ldst +: ENTRY_W] : '0;

  always_comb
  begin
    cur_map_o = prv_map_i;
    // new pdest replaces the ldst entry for lines below
    if (rename_dst)
    begin
      cur_map_o[ENTRY_W*ldst +: ENTRY_W] = {1'b1, pdest};
    end
  end

  always_comb
  begin
    tpu_out_o = '0;
    tpu_out_o[BIT_OUT_WAT]               = inst_wat;
    tpu_out_o[BIT_OUT_INST_VLD]          = inst_vld;
    tpu_out_o[POS_PSRC1 +: ENTRY_W]      = psrc1;
    tpu_out_o[POS_PSRC2 +: ENTRY_W]      = psrc2;
    tpu_out_o[POS_OUT_PDEST +: PTAG_W]   = pdest;
    tpu_out_o[BIT_OUT_LDST_VLD]          = ldst_vld;
    tpu_out_o[BIT_OUT_CTRL]              = isq_lin_i[BIT_CTRL];
  end

  // destination ready, loaded on strobe
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dst_rdy_q <= 1'b0;
    end
    else if (dst_rdy_reg_en_i)
    begin
      dst_rdy_q <= dst_reg_rdy_i;
    end
  end

  assign inst_rdy_o  = inst_vld & dst_rdy_q;
  assign inst_done_o = ~inst_vld | ~inst_wat;

endmodule

/* hw/seg_header_ctrl.sv */
`timescale 1ns/1ps

module seg_header_ctrl
  import rename_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  qptr_t                 qptr_i,
  rename_lines_if.header        lines,
  output rename_map_t           seg0_head_map_o,
  output rename_map_t           seg1_head_map_o,
  output logic                  arch_o,
  output logic                  isq_full_o
);

  // 0 means the top header holds the committed map
  logic        arch_q;
  rename_map_t top_hed_map_q;
  rename_map_t mid_hed_map_q;
  logic        lo_done;
  logic        hi_done;
  logic        arch_swt;
  logic        top_hed_ld;
  logic        mid_hed_ld;

  //////////////////////////////
  // switch condition
  //////////////////////////////

  assign lo_done = &lines.inst_done[SEG_LINES-1:0];
  assign hi_done = &lines.inst_done[ISQ_DEPTH-1:SEG_LINES];

  // committed half drained and writer moved to the other half
  assign arch_swt = (~arch_q & (qptr_i >= qptr_t'(SEG_LINES)) & lo_done) |
                    ( arch_q & (qptr_i <  qptr_t'(SEG_LINES)) & hi_done);

  // header of the segment that becomes committed takes its tail map
  assign mid_hed_ld = ~arch_q & arch_swt;
  assign top_hed_ld =  arch_q & arch_swt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      arch_q <= 1'b0;
    end
    else if (arch_swt)
    begin
      arch_q <= ~arch_q;
    end
  end

  //////////////////////////////
  // header maps
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      top_hed_map_q <= RESET_MAP;
      mid_hed_map_q <= RESET_MAP;
    end
    else
    begin
      if (top_hed_ld)
      begin
        top_hed_map_q <= lines.high_tail_map;
      end
      if (mid_hed_ld)
      begin
        mid_hed_map_q <= lines.low_tail_map;
      end
    end
  end

  // the committed header seeds its own half
  // the younger half continues from the older tail
  assign seg0_head_map_o = arch_q ? lines.high_tail_map : top_hed_map_q;
  assign seg1_head_map_o = arch_q ? mid_hed_map_q : lines.low_tail_map;

  assign arch_o = arch_q;

  // full when the writer nears the end of the younger half
  assign isq_full_o = arch_q ? (qptr_i == qptr_t'(SEG_LINES - 1 - FULL_MARGIN))
                             : (qptr_i == qptr_t'(ISQ_DEPTH - 1 - FULL_MARGIN));

endmodule

/* hw/out_rotator.sv */
`timescale 1ns/1ps

module out_rotator
  import rename_pkg::*;
(
  input  logic                            arch_i,
  rename_lines_if.rotator                 lines,
  output logic [ISQ_DEPTH*TPU_INST_W-1:0] tpu_out_flat_o,
  output logic [ISQ_DEPTH*ENTRY_W-1:0]    fre_preg_flat_o,
  output logic [ISQ_DEPTH-1:0]            inst_rdy_o
);

  //////////////////////////////
  // oldest segment to low lines
  //////////////////////////////

  // arch 1 means the upper half is older, so swap the halves
  // all three outputs move together to keep line alignment
  for (genvar j = 0; j < ISQ_DEPTH; j++)
  begin : g_rot
    assign tpu_out_flat_o[j*TPU_INST_W +: TPU_INST_W] =
      arch_i ? lines.line_out[(j + SEG_LINES) % ISQ_DEPTH]
             : lines.line_out[j];

    assign fre_preg_flat_o[j*ENTRY_W +: ENTRY_W] =
      arch_i ? lines.fre_preg[(j + SEG_LINES) % ISQ_DEPTH]
             : lines.fre_preg[j];

    assign inst_rdy_o[j] =
      arch_i ? lines.inst_rdy[(j + SEG_LINES) % ISQ_DEPTH]
             : lines.inst_rdy[j];
  end

endmodule

/* hw/tpu_top.sv */
`timescale 1ns/1ps

module tpu_top
  import rename_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [ISQ_DEPTH*ISQ_LINE_W-1:0] isq_flat_i,
  input  qptr_t                           qptr_i,
  input  logic [ISQ_DEPTH-1:0]            dst_reg_rdy_i,
  input  logic [ISQ_DEPTH-1:0]            dst_rdy_reg_en_i,
  output logic [ISQ_DEPTH*TPU_INST_W-1:0] tpu_out_flat_o,
  output logic [ISQ_DEPTH*ENTRY_W-1:0]    fre_preg_flat_o,
  output logic [ISQ_DEPTH-1:0]            inst_rdy_o,
  output logic                            isq_full_o
);

  // queue lines after unflattening
  isq_line_t   isq_lin [ISQ_DEPTH];
  // map seen by each line and map it leaves behind
  rename_map_t prv_map [ISQ_DEPTH];
  rename_map_t cur_map [ISQ_DEPTH];
  rename_map_t seg0_head_map;
  rename_map_t seg1_head_map;
  logic        arch;

  rename_lines_if lines_if ();

  //////////////////////////////
  // line array and map chain
  //////////////////////////////

  for (genvar k = 0; k < ISQ_DEPTH; k++)
  begin : g_line
    assign isq_lin[k] = isq_flat_i[k*ISQ_LINE_W +: ISQ_LINE_W];

    // each half starts from its segment head
    if (k == 0)
    begin : g_seg0
      assign prv_map[k] = seg0_head_map;
    end
    else if (k == SEG_LINES)
    begin : g_seg1
      assign prv_map[k] = seg1_head_map;
    end
    else
    begin : g_chain
      assign prv_map[k] = cur_map[k-1];
    end

    tpu_line u_line (
      .clk              (clk),
      .rst_n            (rst_n),
      .isq_lin_i        (isq_lin[k]),
      .prv_map_i        (prv_map[k]),
      .dst_reg_rdy_i    (dst_reg_rdy_i[k]),
      .dst_rdy_reg_en_i (dst_rdy_reg_en_i[k]),
      .cur_map_o        (cur_map[k]),
      .tpu_out_o        (lines_if.line_out[k]),
      .fre_preg_o       (lines_if.fre_preg[k]),
      .inst_rdy_o       (lines_if.inst_rdy[k]),
      .inst_done_o      (lines_if.inst_done[k])
    );
  end

  // tails of both halves go to the header logic
  assign lines_if.low_tail_map  = cur_map[SEG_LINES-1];
  assign lines_if.high_tail_map = cur_map[ISQ_DEPTH-1];

  //////////////////////////////
  // headers and output order
  //////////////////////////////

  seg_header_ctrl u_hdr (
    .clk             (clk),
    .rst_n           (rst_n),
    .qptr_i          (qptr_i),
    .lines           (lines_if.header),
    .seg0_head_map_o (seg0_head_map),
    .seg1_head_map_o (seg1_head_map),
    .arch_o          (arch),
    .isq_full_o      (isq_full_o)
  );

  out_rotator u_rot (
    .arch_i          (arch),
    .lines           (lines_if.rotator),
    .tpu_out_flat_o  (tpu_out_flat_o),
    .fre_preg_flat_o (fre_preg_flat_o),
    .inst_rdy_o      (inst_rdy_o)
  );

endmodule

/* bench/tpu_properties.sv */
`timescale 1ns/1ps

module tpu_properties
  import rename_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input qptr_t       qptr_i,
  input logic        lo_done,
  input logic        hi_done,
  input logic        arch_q,
  input rename_map_t top_hed_map_q,
  input rename_map_t mid_hed_map_q
);

  // switch rule rebuilt from the pointer and the drain flags
  logic swt_cond;

  assign swt_cond = (!arch_q && (qptr_i >= qptr_t'(SEG_LINES)) && lo_done) ||
                    ( arch_q && (qptr_i <  qptr_t'(SEG_LINES)) && hi_done);

  //////////////////////////////
  // header controller rules
  //////////////////////////////

  // arch only toggles on an edge where the switch held
  arch_toggle_on_switch: assert property (@(posedge clk) disable iff (!rst_n)
    (arch_q != $past(arch_q)) |-> $past(swt_cond))
    else $error("arch changed without a switch condition");

  // only the header of the newly committed half may change
  one_header_load: assert property (@(posedge clk) disable iff (!rst_n)
    !((top_hed_map_q != $past(top_hed_map_q)) && (mid_hed_map_q != $past(mid_hed_map_q))))
    else $error("both headers loaded on the same edge");

  // first edge out of reset still sees the identity maps
  headers_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> (top_hed_map_q == RESET_MAP) && (mid_hed_map_q == RESET_MAP))
    else $error("headers differ from the reset map after reset");

endmodule

/* bench/tpu_tb.sv */
`timescale 1ns/1ps

module tpu_tb
  import rename_pkg::*;
();

  // widest value the compare task handles
  localparam int CW       = 512;
  localparam int MAX_WAIT = 8;

  // expected state of the stage for one cycle
  typedef struct packed {
    logic [ISQ_DEPTH*TPU_INST_W-1:0] tpu_flat;
    logic [ISQ_DEPTH*ENTRY_W-1:0]    fre_flat;
    logic [ISQ_DEPTH-1:0]            rdy;
    logic                            full;
    logic                            swt;
    rename_map_t                     lo_tail;
    rename_map_t                     hi_tail;
  } expect_t;

  logic                            clk;
  logic                            rst_n;
  logic [ISQ_DEPTH*ISQ_LINE_W-1:0] isq_flat;
  qptr_t                           qptr;
  logic [ISQ_DEPTH-1:0]            dst_rdy;
  logic [ISQ_DEPTH-1:0]            dst_en;
  logic [ISQ_DEPTH*TPU_INST_W-1:0] tpu_out_flat;
  logic [ISQ_DEPTH*ENTRY_W-1:0]    fre_preg_flat;
  logic [ISQ_DEPTH-1:0]            inst_rdy;
  logic                            isq_full;

  // model of arch, both headers and the per-line ready flags
  logic                            arch_m;
  rename_map_t                     top_m;
  rename_map_t                     mid_m;
  logic [ISQ_DEPTH-1:0]            rdy_m;
  expect_t                         exp_now;
  string                           test_name;

  tpu_top DUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .isq_flat_i       (isq_flat),
    .qptr_i           (qptr),
    .dst_reg_rdy_i    (dst_rdy),
    .dst_rdy_reg_en_i (dst_en),
    .tpu_out_flat_o   (tpu_out_flat),
    .fre_preg_flat_o  (fre_preg_flat),
    .inst_rdy_o       (inst_rdy),
    .isq_full_o       (isq_full)
  );

  bind seg_header_ctrl tpu_properties u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .qptr_i        (qptr_i),
    .lo_done       (lo_done),
    .hi_done       (hi_done),
    .arch_q        (arch_q),
    .top_hed_map_q (top_hed_map_q),
    .mid_hed_map_q (mid_hed_map_q)
  );

  always #2 clk = ~clk;

  //////////////////////////////
  // reference model
  //////////////////////////////

  // valid flag set above tag n in entry n
  function automatic rename_map_t build_identity_map();
    rename_map_t m;
    m = '0;
    for (int n = 0; n < NUM_LREGS; n++)
    begin
      m[n*ENTRY_W + PTAG_W] = 1'b1;
      m[n*ENTRY_W +: PTAG_W] = n[PTAG_W-1:0];
    end
    return m;
  endfunction

  // walk lines oldest first from the committed header
  // the chain runs on across the half boundary
  function automatic expect_t expected_outputs(
    input logic [ISQ_DEPTH*ISQ_LINE_W-1:0] lines,
    input qptr_t                           ptr,
    input logic                            arch,
    input rename_map_t                     top,
    input rename_map_t                     mid,
    input logic [ISQ_DEPTH-1:0]            flags
  );
    expect_t              e;
    rename_map_t          map;
    isq_line_t            ln;
    lreg_t                s1_reg;
    lreg_t                s2_reg;
    lreg_t                d_reg;
    map_entry_t           s1;
    map_entry_t           s2;
    map_entry_t           old;
    logic [ISQ_DEPTH-1:0] done;
    int                   k;
    int                   younger_last;
    e    = '0;
    done = '0;
    map  = arch ? mid : top;
    for (int i = 0; i < ISQ_DEPTH; i++)
    begin
      k      = arch ? (i + SEG_LINES) % ISQ_DEPTH : i;
      ln     = lines[k*ISQ_LINE_W +: ISQ_LINE_W];
      s1_reg = ln[POS_LSRC1 +: LREG_W];
      s2_reg = ln[POS_LSRC2 +: LREG_W];
      d_reg  = ln[POS_LDST +: LREG_W];
      s1     = ln[BIT_LSRC1_VLD] ? map[s1_reg*ENTRY_W +: ENTRY_W] : '0;
      s2     = ln[BIT_LSRC2_VLD] ? map[s2_reg*ENTRY_W +: ENTRY_W] : '0;
      old    = '0;
      if (ln[BIT_INST_VLD] && ln[BIT_LDST_VLD])
      begin
        old = map[d_reg*ENTRY_W +: ENTRY_W];
        map[d_reg*ENTRY_W +: ENTRY_W] = {1'b1, ln[POS_PDEST +: PTAG_W]};
      end
      // rotated position i holds raw line k
      e.tpu_flat[i*TPU_INST_W +: TPU_INST_W] = {ln[BIT_WAT], ln[BIT_INST_VLD], s1, s2,
        ln[POS_PDEST +: PTAG_W], ln[BIT_LDST_VLD], ln[BIT_CTRL], 1'b0};
      e.fre_flat[i*ENTRY_W +: ENTRY_W] = old;
      e.rdy[i] = ln[BIT_INST_VLD] & flags[k];
      done[k]  = ~ln[BIT_INST_VLD] | ~ln[BIT_WAT];
      if (k == SEG_LINES - 1)
        e.lo_tail = map;
      if (k == ISQ_DEPTH - 1)
        e.hi_tail = map;
    end
    // last slot of the half that is not committed
    younger_last = arch ? SEG_LINES - 1 : ISQ_DEPTH - 1;
    e.full = (int'(ptr) == younger_last - FULL_MARGIN);
    e.swt  = (!arch && ptr >= qptr_t'(SEG_LINES) && (&done[SEG_LINES-1:0])) ||
             ( arch && ptr <  qptr_t'(SEG_LINES) && (&done[ISQ_DEPTH-1:SEG_LINES]));
    return e;
  endfunction

  task automatic check_value(input string what, input logic [CW-1:0] exp_v,
                             input logic [CW-1:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("Error: test %s, %s expected %0h actual %0h", test_name, what, exp_v, act_v);
      $display("TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // sample 1 ns before the edge, then advance the model past it
  always @(posedge clk)
  begin
    #3;
    if (rst_n)
    begin
      exp_now = expected_outputs(isq_flat, qptr, arch_m, top_m, mid_m, rdy_m);
      check_value("tpu_out", CW'(exp_now.tpu_flat), CW'(tpu_out_flat));
      check_value("fre_preg", CW'(exp_now.fre_flat), CW'(fre_preg_flat));
      check_value("inst_rdy", CW'(exp_now.rdy), CW'(inst_rdy));
      check_value("isq_full", CW'(exp_now.full), CW'(isq_full));
      check_value("arch", CW'(arch_m), CW'(DUT.u_hdr.arch_o));
      check_value("top header", CW'(top_m), CW'(DUT.u_hdr.top_hed_map_q));
      check_value("mid header", CW'(mid_m), CW'(DUT.u_hdr.mid_hed_map_q));
      if (exp_now.swt)
      begin
        if (arch_m)
          top_m = exp_now.hi_tail;
        else
          mid_m = exp_now.lo_tail;
        arch_m = ~arch_m;
      end
      rdy_m = (rdy_m & ~dst_en) | (dst_rdy & dst_en);
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  function automatic isq_line_t rand_line(input logic vld, input logic wt, input logic with_dst);
    isq_line_t ln;
    ln = isq_line_t'($urandom);
    ln[BIT_WAT]      = wt;
    ln[BIT_INST_VLD] = vld;
    // most lines with a destination really write one
    ln[BIT_LDST_VLD] = with_dst && ($urandom % 4 != 0);
    return ln;
  endfunction

  task automatic fill_lines(input logic [ISQ_DEPTH-1:0] vld, input logic [ISQ_DEPTH-1:0] wt,
                            input logic with_dst);
    for (int k = 0; k < ISQ_DEPTH; k++)
      isq_flat[k*ISQ_LINE_W +: ISQ_LINE_W] = rand_line(vld[k], wt[k], with_dst);
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic random_strobes();
    dst_en  = ISQ_DEPTH'($urandom);
    dst_rdy = ISQ_DEPTH'($urandom);
  endtask

  task automatic wait_arch(input logic target);
    int n;
    n = 0;
    while (DUT.u_hdr.arch_o !== target)
    begin
      if (n >= MAX_WAIT)
      begin
        $display("arch did not switch to %0d within %0d cycles", target, MAX_WAIT);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
      end
      step_cycle();
      n++;
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    int                   hold;
    logic [ISQ_DEPTH-1:0] wt_mask;
    clk       = 1'b0;
    rst_n     = 1'b0;
    isq_flat  = '0;
    qptr      = '0;
    dst_rdy   = '0;
    dst_en    = '0;
    arch_m    = 1'b0;
    top_m     = build_identity_map();
    mid_m     = build_identity_map();
    rdy_m     = '0;
    test_name = "reset";
    void'($urandom(32'hac33));
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // no destinations, so every source sees the identity map
    test_name = "identity after reset";
    for (int n = 0; n < 6; n++)
    begin
      fill_lines('1, '1, 1'b0);
      qptr = qptr_t'($urandom % SEG_LINES);
      step_cycle();
    end

    // pointer kept low so arch stays 0
    test_name = "map chain";
    for (int n = 0; n < 10; n++)
    begin
      fill_lines(ISQ_DEPTH'($urandom | $urandom), ISQ_DEPTH'($urandom), 1'b1);
      qptr = qptr_t'($urandom % SEG_LINES);
      step_cycle();
    end

    test_name = "ready strobe";
    for (int n = 0; n < 10; n++)
    begin
      fill_lines(ISQ_DEPTH'($urandom | $urandom), '1, 1'b1);
      random_strobes();
      qptr = qptr_t'($urandom % SEG_LINES);
      step_cycle();
    end
    dst_en = '0;

    // lower half drained, writer in the upper half
    test_name = "segment switch";
    fill_lines('1, {{SEG_LINES{1'b1}}, {SEG_LINES{1'b0}}}, 1'b1);
    qptr = qptr_t'(SEG_LINES + 2);
    wait_arch(1'b1);
    for (int n = 0; n < 8; n++)
    begin
      fill_lines({{SEG_LINES{1'b1}}, SEG_LINES'($urandom)},
                 {{SEG_LINES{1'b1}}, SEG_LINES'($urandom)}, 1'b1);
      random_strobes();
      qptr = qptr_t'($urandom);
      step_cycle();
    end
    dst_en = '0;
    test_name = "switch back";
    fill_lines('1, {{SEG_LINES{1'b0}}, {SEG_LINES{1'b1}}}, 1'b1);
    qptr = qptr_t'(2);
    wait_arch(1'b0);

    test_name = "full flag arch 0";
    for (int q = 0; q < ISQ_DEPTH; q++)
    begin
      fill_lines('1, '1, 1'b1);
      qptr = qptr_t'(q);
      step_cycle();
      check_value("arch", CW'(1'b0), CW'(DUT.u_hdr.arch_o));
    end

    test_name = "switch to upper";
    fill_lines('1, {{SEG_LINES{1'b1}}, {SEG_LINES{1'b0}}}, 1'b1);
    qptr = qptr_t'(ISQ_DEPTH - 4);
    wait_arch(1'b1);

    // one waiting line in the committed half blocks the switch
    test_name = "held wait bit";
    hold = SEG_LINES + int'($urandom % SEG_LINES);
    for (int q = 0; q < ISQ_DEPTH; q++)
    begin
      wt_mask = ISQ_DEPTH'($urandom);
      wt_mask[ISQ_DEPTH-1:SEG_LINES] = '0;
      wt_mask[hold] = 1'b1;
      fill_lines('1, wt_mask, 1'b1);
      qptr = qptr_t'(q);
      step_cycle();
      check_value("arch", CW'(1'b1), CW'(DUT.u_hdr.arch_o));
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* sources.f */
hw/rename_pkg.sv
hw/rename_lines_if.sv
hw/tpu_line.sv
hw/seg_header_ctrl.sv
hw/out_rotator.sv
hw/tpu_top.sv
bench/tpu_properties.sv
bench/tpu_tb.sv

/* Makefile */
# Verilator flow for the rename stage

VERILATOR ?= verilator
TOP       ?= tpu_tb
RTL_TOP   ?= tpu_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
FAIL_MSG  ?= TESTS FAILED
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint build sim clean

all: sim

# lint the synthesizable design from its top level
lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides the result, not the exit status of the binary
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
